// ==== include/noc_consts.svh ====
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Width of one flit in bits
`define FLIT_W 16

// Input buffer entries, also the credits a fresh downstream link starts with
`define BUF_DEPTH 8

// Wide enough to hold BUF_DEPTH
`define CREDIT_W 4

`define NUM_PORTS 4

`endif

// ==== list.f ====
+incdir+include
src/noc_flit_pkg.sv
src/noc_port_pkg.sv
src/input_buffer.sv
src/credit_counter.sv
src/yx_switch_allocator.sv
src/crossbar_switch.sv
src/n_edge_router.sv
verification/n_edge_router_assertions.sv
verification/n_edge_router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module n_edge_router_tb -o n_edge_router_sim

out=$(./obj_dir/n_edge_router_sim)
printf '%s\n' "$out"

# Non-zero exit when the pass line is missing
printf '%s\n' "$out" | grep -q "All tests passed"

// ==== src/credit_counter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "noc_consts.svh"

module credit_counter (
  input  logic clk,
  input  logic arst_n_i,
  input  logic consume_i,
  input  logic return_i,
  output logic has_credit_o
);

  // Free slots in the downstream buffer
  logic [`CREDIT_W-1:0] count_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= `CREDIT_W'(`BUF_DEPTH);
    end else begin
      case ({consume_i, return_i})
        2'b10:   count_q <= count_q - 1'b1;
        2'b01:   count_q <= count_q + 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign has_credit_o = (count_q != '0);

endmodule

`default_nettype wire

// ==== src/crossbar_switch.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "noc_consts.svh"

module crossbar_switch (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  noc_flit_pkg::flit_t      s_flit_i,
  input  noc_flit_pkg::flit_t      w_flit_i,
  input  noc_flit_pkg::flit_t      e_flit_i,
  input  noc_flit_pkg::flit_t      l_flit_i,
  input  noc_port_pkg::port_mask_t s_grant_i,
  input  noc_port_pkg::port_mask_t w_grant_i,
  input  noc_port_pkg::port_mask_t e_grant_i,
  input  noc_port_pkg::port_mask_t l_grant_i,
  output noc_flit_pkg::flit_t      s_data_o,
  output noc_flit_pkg::flit_t      w_data_o,
  output noc_flit_pkg::flit_t      e_data_o,
  output noc_flit_pkg::flit_t      l_data_o,
  output logic                     s_valid_o,
  output logic                     w_valid_o,
  output logic                     e_valid_o,
  output logic                     l_valid_o
);

  import noc_flit_pkg::*;
  import noc_port_pkg::*;

  flit_t                 flit    [`NUM_PORTS];
  port_mask_t            grant   [`NUM_PORTS];
  flit_t                 sel     [`NUM_PORTS];
  flit_t                 data_q  [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] valid_q;

  assign flit  = '{s_flit_i, w_flit_i, e_flit_i, l_flit_i};
  assign grant = '{s_grant_i, w_grant_i, e_grant_i, l_grant_i};

  // Grants are one-hot, so at most one input matches
  always_comb begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      sel[o] = '0;
      for (int i = 0; i < `NUM_PORTS; i++) begin
        if (grant[o][i]) begin
          sel[o] = flit[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      data_q[o] <= sel[o];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      for (int o = 0; o < `NUM_PORTS; o++) begin
        valid_q[o] <= |grant[o];
      end
    end
  end

  assign s_data_o  = data_q[PORT_S];
  assign w_data_o  = data_q[PORT_W];
  assign e_data_o  = data_q[PORT_E];
  assign l_data_o  = data_q[PORT_L];
  assign s_valid_o = valid_q[PORT_S];
  assign w_valid_o = valid_q[PORT_W];
  assign e_valid_o = valid_q[PORT_E];
  assign l_valid_o = valid_q[PORT_L];

endmodule

`default_nettype wire

// ==== src/input_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "noc_consts.svh"

module input_buffer (
  input  logic                clk,
  input  logic                arst_n_i,
  input  noc_flit_pkg::flit_t data_i,
  input  logic                write_i,
  input  logic                pop_i,
  output noc_flit_pkg::flit_t data_o,
  output logic                not_empty_o
);

  import noc_flit_pkg::*;

  localparam int PTR_W = $clog2(`BUF_DEPTH);
  localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

  flit_t            mem_q [`BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_write;
  logic             do_pop;

  assign full        = (count_q == CNT_W'(`BUF_DEPTH));
  assign not_empty_o = (count_q != '0);
  assign do_write    = write_i & ~full;
  assign do_pop      = pop_i & not_empty_o;

  // Head flit is visible without a read cycle
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_write, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/n_edge_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module n_edge_router (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  noc_flit_pkg::yx_addr_t yx_addr_router_i,
  input  noc_flit_pkg::flit_t    s_data_i,
  input  noc_flit_pkg::flit_t    w_data_i,
  input  noc_flit_pkg::flit_t    e_data_i,
  input  noc_flit_pkg::flit_t    l_data_i,
  input  logic                   s_valid_i,
  input  logic                   w_valid_i,
  input  logic                   e_valid_i,
  input  logic                   l_valid_i,
  input  logic                   s_credit_i,
  input  logic                   w_credit_i,
  input  logic                   e_credit_i,
  input  logic                   l_credit_i,
  output noc_flit_pkg::flit_t    s_data_o,
  output noc_flit_pkg::flit_t    w_data_o,
  output noc_flit_pkg::flit_t    e_data_o,
  output noc_flit_pkg::flit_t    l_data_o,
  output logic                   s_valid_o,
  output logic                   w_valid_o,
  output logic                   e_valid_o,
  output logic                   l_valid_o,
  output logic                   s_credit_o,
  output logic                   w_credit_o,
  output logic                   e_credit_o,
  output logic                   l_credit_o
);

  import noc_flit_pkg::*;
  import noc_port_pkg::*;

  flit_t      s_head, w_head, e_head, l_head;
  logic       s_not_empty, w_not_empty, e_not_empty, l_not_empty;
  logic       s_pop, w_pop, e_pop, l_pop;
  logic       s_has_credit, w_has_credit, e_has_credit, l_has_credit;
  logic       s_consume, w_consume, e_consume, l_consume;
  port_mask_t s_grant, w_grant, e_grant, l_grant;

  input_buffer ib_s (.clk(clk), .arst_n_i(arst_n_i), .data_i(s_data_i), .write_i(s_valid_i),
                     .pop_i(s_pop), .data_o(s_head), .not_empty_o(s_not_empty));
  input_buffer ib_w (.clk(clk), .arst_n_i(arst_n_i), .data_i(w_data_i), .write_i(w_valid_i),
                     .pop_i(w_pop), .data_o(w_head), .not_empty_o(w_not_empty));
  input_buffer ib_e (.clk(clk), .arst_n_i(arst_n_i), .data_i(e_data_i), .write_i(e_valid_i),
                     .pop_i(e_pop), .data_o(e_head), .not_empty_o(e_not_empty));
  input_buffer ib_l (.clk(clk), .arst_n_i(arst_n_i), .data_i(l_data_i), .write_i(l_valid_i),
                     .pop_i(l_pop), .data_o(l_head), .not_empty_o(l_not_empty));

  // One counter per output, refilled by the downstream credit pulses
  credit_counter cc_s (.clk(clk), .arst_n_i(arst_n_i), .consume_i(s_consume),
                       .return_i(s_credit_i), .has_credit_o(s_has_credit));
  credit_counter cc_w (.clk(clk), .arst_n_i(arst_n_i), .consume_i(w_consume),
                       .return_i(w_credit_i), .has_credit_o(w_has_credit));
  credit_counter cc_e (.clk(clk), .arst_n_i(arst_n_i), .consume_i(e_consume),
                       .return_i(e_credit_i), .has_credit_o(e_has_credit));
  credit_counter cc_l (.clk(clk), .arst_n_i(arst_n_i), .consume_i(l_consume),
                       .return_i(l_credit_i), .has_credit_o(l_has_credit));

  yx_switch_allocator sa_inner (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .router_addr_i(yx_addr_router_i),
    .s_head_i(s_head), .w_head_i(w_head), .e_head_i(e_head), .l_head_i(l_head),
    .s_not_empty_i(s_not_empty), .w_not_empty_i(w_not_empty),
    .e_not_empty_i(e_not_empty), .l_not_empty_i(l_not_empty),
    .s_has_credit_i(s_has_credit), .w_has_credit_i(w_has_credit),
    .e_has_credit_i(e_has_credit), .l_has_credit_i(l_has_credit),
    .s_pop_o(s_pop), .w_pop_o(w_pop), .e_pop_o(e_pop), .l_pop_o(l_pop),
    .s_consume_o(s_consume), .w_consume_o(w_consume),
    .e_consume_o(e_consume), .l_consume_o(l_consume),
    .s_grant_o(s_grant), .w_grant_o(w_grant), .e_grant_o(e_grant), .l_grant_o(l_grant)
  );

  crossbar_switch cs_inner (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .s_flit_i(s_head), .w_flit_i(w_head), .e_flit_i(e_head), .l_flit_i(l_head),
    .s_grant_i(s_grant), .w_grant_i(w_grant), .e_grant_i(e_grant), .l_grant_i(l_grant),
    .s_data_o(s_data_o), .w_data_o(w_data_o), .e_data_o(e_data_o), .l_data_o(l_data_o),
    .s_valid_o(s_valid_o), .w_valid_o(w_valid_o),
    .e_valid_o(e_valid_o), .l_valid_o(l_valid_o)
  );

  // Every pop frees one upstream slot
  assign s_credit_o = s_pop;
  assign w_credit_o = w_pop;
  assign e_credit_o = e_pop;
  assign l_credit_o = l_pop;

endmodule

`default_nettype wire

// ==== src/noc_flit_pkg.sv ====
`default_nettype none
`include "noc_consts.svh"

package noc_flit_pkg;

  typedef logic [`FLIT_W-1:0] flit_t;
  typedef logic [3:0] coord_t;

  // Router address, y in the upper nibble
  typedef struct packed {
    coord_t y;
    coord_t x;
  } yx_addr_t;

  function automatic coord_t dest_y(flit_t f);
    return f[15:12];
  endfunction

  function automatic coord_t dest_x(flit_t f);
    return f[11:8];
  endfunction

endpackage

`default_nettype wire

// ==== src/noc_port_pkg.sv ====
`default_nettype none
`include "noc_consts.svh"

package noc_port_pkg;

  // Order also sets the bit positions of port_mask_t
  typedef enum logic [1:0] {
    PORT_S = 2'd0,
    PORT_W = 2'd1,
    PORT_E = 2'd2,
    PORT_L = 2'd3
  } port_e;

  // One-hot, one bit per port
  typedef logic [`NUM_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

// ==== src/yx_switch_allocator.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "noc_consts.svh"

module yx_switch_allocator (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  noc_flit_pkg::yx_addr_t   router_addr_i,
  input  noc_flit_pkg::flit_t      s_head_i,
  input  noc_flit_pkg::flit_t      w_head_i,
  input  noc_flit_pkg::flit_t      e_head_i,
  input  noc_flit_pkg::flit_t      l_head_i,
  input  logic                     s_not_empty_i,
  input  logic                     w_not_empty_i,
  input  logic                     e_not_empty_i,
  input  logic                     l_not_empty_i,
  input  logic                     s_has_credit_i,
  input  logic                     w_has_credit_i,
  input  logic                     e_has_credit_i,
  input  logic                     l_has_credit_i,
  output logic                     s_pop_o,
  output logic                     w_pop_o,
  output logic                     e_pop_o,
  output logic                     l_pop_o,
  output logic                     s_consume_o,
  output logic                     w_consume_o,
  output logic                     e_consume_o,
  output logic                     l_consume_o,
  output noc_port_pkg::port_mask_t s_grant_o,
  output noc_port_pkg::port_mask_t w_grant_o,
  output noc_port_pkg::port_mask_t e_grant_o,
  output noc_port_pkg::port_mask_t l_grant_o
);

  import noc_flit_pkg::*;
  import noc_port_pkg::*;

  localparam int PTR_W = $clog2(`NUM_PORTS);

  flit_t                 head       [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] not_empty;
  logic [`NUM_PORTS-1:0] has_credit;
  // route is indexed by input, grant by output
  port_mask_t            route      [`NUM_PORTS];
  port_mask_t            grant      [`NUM_PORTS];
  logic [PTR_W-1:0]      grant_idx  [`NUM_PORTS];
  logic [PTR_W-1:0]      rr_ptr_q   [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] pop;

  // Leave the row first, then move along x
  function automatic port_e route_of(flit_t f, yx_addr_t here);
    port_e p;
    if (dest_y(f) != here.y) begin
      p = PORT_S;
    end else if (dest_x(f) > here.x) begin
      p = PORT_E;
    end else if (dest_x(f) < here.x) begin
      p = PORT_W;
    end else begin
      p = PORT_L;
    end
    return p;
  endfunction

  assign head       = '{s_head_i, w_head_i, e_head_i, l_head_i};
  assign not_empty  = {l_not_empty_i, e_not_empty_i, w_not_empty_i, s_not_empty_i};
  assign has_credit = {l_has_credit_i, e_has_credit_i, w_has_credit_i, s_has_credit_i};

  always_comb begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      route[i] = '0;
      if (not_empty[i]) begin
        route[i][route_of(head[i], router_addr_i)] = 1'b1;
      end
    end
  end

  // Search starts at the pointer, first requester wins
  always_comb begin
    logic [PTR_W-1:0] idx;
    logic             found;
    for (int o = 0; o < `NUM_PORTS; o++) begin
      grant[o]     = '0;
      grant_idx[o] = rr_ptr_q[o];
      found        = 1'b0;
      for (int k = 0; k < `NUM_PORTS; k++) begin
        idx = rr_ptr_q[o] + PTR_W'(k);
        if (has_credit[o] && !found && route[idx][o]) begin
          grant[o][idx] = 1'b1;
          grant_idx[o]  = idx;
          found         = 1'b1;
        end
      end
    end
  end

  // An input routes to one output only, so OR-ing the grants is safe
  always_comb begin
    pop = '0;
    for (int o = 0; o < `NUM_PORTS; o++) begin
      pop = pop | grant[o];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int o = 0; o < `NUM_PORTS; o++) begin
        rr_ptr_q[o] <= PTR_W'(PORT_S);
      end
    end else begin
      for (int o = 0; o < `NUM_PORTS; o++) begin
        if (|grant[o]) begin
          rr_ptr_q[o] <= grant_idx[o] + 1'b1;
        end
      end
    end
  end

  assign s_pop_o     = pop[PORT_S];
  assign w_pop_o     = pop[PORT_W];
  assign e_pop_o     = pop[PORT_E];
  assign l_pop_o     = pop[PORT_L];
  assign s_consume_o = |grant[PORT_S];
  assign w_consume_o = |grant[PORT_W];
  assign e_consume_o = |grant[PORT_E];
  assign l_consume_o = |grant[PORT_L];
  assign s_grant_o   = grant[PORT_S];
  assign w_grant_o   = grant[PORT_W];
  assign e_grant_o   = grant[PORT_E];
  assign l_grant_o   = grant[PORT_L];

endmodule

`default_nettype wire

// ==== verification/n_edge_router_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module n_edge_router_assertions (
  input logic       clk,
  input logic       arst_n_i,
  input logic [3:0] in_valid_i,
  input logic [3:0] in_full_i,
  input logic [3:0] out_valid_i,
  input logic [3:0] out_no_credit_i,
  input logic [3:0] up_credit_i
);

  // Upstream only sends while it holds a credit
  no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n_i)
    (in_valid_i & in_full_i) == 4'b0)
    else $error("valid input at a full input buffer");

  // The grant behind a flit was made while the counter was above zero
  no_send_without_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
    (out_valid_i & $past(out_no_credit_i)) == 4'b0)
    else $error("output flit sent while its credit counter was zero");

  credits_low_after_reset: assert property (@(posedge clk)
    $rose(arst_n_i) |-> up_credit_i == 4'b0)
    else $error("credit output high in the first cycle after reset");

endmodule

bind n_edge_router n_edge_router_assertions chk0 (
  .clk(clk),
  .arst_n_i(arst_n_i),
  .in_valid_i({l_valid_i, e_valid_i, w_valid_i, s_valid_i}),
  .in_full_i({ib_l.full, ib_e.full, ib_w.full, ib_s.full}),
  .out_valid_i({l_valid_o, e_valid_o, w_valid_o, s_valid_o}),
  .out_no_credit_i(~{l_has_credit, e_has_credit, w_has_credit, s_has_credit}),
  .up_credit_i({l_credit_o, e_credit_o, w_credit_o, s_credit_o})
);

`default_nettype wire

// ==== verification/n_edge_router_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "noc_consts.svh"

module n_edge_router_tb;

  import noc_flit_pkg::*;

  localparam int NTESTS = 5;

  logic                  clk;
  logic                  arst_n;
  yx_addr_t              addr;
  flit_t                 data_i [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] valid_i;
  logic [`NUM_PORTS-1:0] credit_i;
  flit_t                 data_o [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] valid_o;
  logic [`NUM_PORTS-1:0] credit_o;

  logic [15:0] recs [256];
  // Pending injections per input, expected port in the top two bits
  logic [17:0] pend [`NUM_PORTS][$];
  // Expected flits, indexed by output * 4 + input
  flit_t       exp_q [16][$];
  string       pname [`NUM_PORTS] = '{"s", "w", "e", "l"};
  string       tname [NTESTS+1] = '{"", "quiet after reset", "YX routing",
                                     "back-pressure and order", "round-robin fairness",
                                     "upstream credits"};
  int          up_credit [`NUM_PORTS];
  int          injected [`NUM_PORTS];
  int          pulses [`NUM_PORTS];
  int          owed [`NUM_PORTS];
  int          test_err [NTESTS+1];
  int          cur_test;
  int          nrec;
  int          limit;
  int          cycles;
  int          e_arrivals;
  int          prev_l;
  bit          hold_e;
  bit          loaded;

  n_edge_router dut0 (
    .clk(clk),
    .arst_n_i(arst_n),
    .yx_addr_router_i(addr),
    .s_data_i(data_i[0]), .w_data_i(data_i[1]), .e_data_i(data_i[2]), .l_data_i(data_i[3]),
    .s_valid_i(valid_i[0]), .w_valid_i(valid_i[1]),
    .e_valid_i(valid_i[2]), .l_valid_i(valid_i[3]),
    .s_credit_i(credit_i[0]), .w_credit_i(credit_i[1]),
    .e_credit_i(credit_i[2]), .l_credit_i(credit_i[3]),
    .s_data_o(data_o[0]), .w_data_o(data_o[1]), .e_data_o(data_o[2]), .l_data_o(data_o[3]),
    .s_valid_o(valid_o[0]), .w_valid_o(valid_o[1]),
    .e_valid_o(valid_o[2]), .l_valid_o(valid_o[3]),
    .s_credit_o(credit_o[0]), .w_credit_o(credit_o[1]),
    .e_credit_o(credit_o[2]), .l_credit_o(credit_o[3])
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic bit drained();
    for (int i = 0; i < 16; i++) begin
      if (exp_q[i].size() > 0) return 1'b0;
    end
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (pend[p].size() > 0 || owed[p] > 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic queue_records(input int t);
    flit_t f;
    int    src;
    int    dst;
    for (int r = 0; r < nrec; r++) begin
      if (recs[4*r] == 16'(t)) begin
        src = int'(recs[4*r+1]);
        dst = int'(recs[4*r+2]);
        f   = recs[4*r+3];
        pend[src].push_back({2'(dst), f});
      end
    end
  endtask

  task automatic take_arrival(input int o, input flit_t f);
    int    src;
    int    nxt;
    bit    pending;
    flit_t shown;
    src     = -1;
    pending = 1'b0;
    shown   = '0;
    for (int s = 3; s >= 0; s--) begin
      if (exp_q[o*4+s].size() > 0) begin
        pending = 1'b1;
        shown   = exp_q[o*4+s][0];
        if (exp_q[o*4+s][0] == f) src = s;
      end
    end
    assert (src >= 0) else begin
      if (pending) begin
        $display("Fail %0t: %s_data_o expected %h got %h", $time, pname[o], shown, f);
      end else begin
        $display("Flit %h came out on %s_data_o at %0t with nothing expected there",
                 f, pname[o], $time);
      end
      test_err[cur_test]++;
    end
    if (src >= 0) begin
      // Next source after the last one served that still has traffic
      if (o == 3 && cur_test == 4) begin
        if (prev_l >= 0 && exp_q[12].size() > 0 && exp_q[13].size() > 0
            && exp_q[14].size() > 0) begin
          nxt = -1;
          for (int k = 4; k >= 1; k--) begin
            if (exp_q[12 + (prev_l + k) % 4].size() > 0) nxt = (prev_l + k) % 4;
          end
          assert (src == nxt) else begin
            $display("Fail %0t: l_data_o source expected %s got %s",
                     $time, pname[nxt], pname[src]);
            test_err[cur_test]++;
          end
        end
        prev_l = src;
      end
      void'(exp_q[o*4+src].pop_front());
    end
    if (o == 2) e_arrivals++;
    owed[o]++;
  endtask

  task automatic report(input int t);
    if (test_err[t] == 0) begin
      $display("Test %0d %s: pass", t, tname[t]);
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", t, tname[t], test_err[t]);
    end
  endtask

  // Sample, return credits and inject, all on the rising edge
  always @(posedge clk) begin
    if (arst_n) begin
      for (int p = 0; p < `NUM_PORTS; p++) begin
        if (cur_test == 1) begin
          assert (!valid_o[p]) else begin
            $display("Fail %0t: %s_valid_o expected 0 got %b", $time, pname[p], valid_o[p]);
            test_err[1]++;
          end
          assert (!credit_o[p]) else begin
            $display("Fail %0t: %s_credit_o expected 0 got %b", $time, pname[p], credit_o[p]);
            test_err[1]++;
          end
        end
        if (credit_o[p]) begin
          up_credit[p]++;
          pulses[p]++;
        end
        if (valid_o[p]) take_arrival(p, data_o[p]);
        if (owed[p] > 0 && !(p == 2 && hold_e)) begin
          credit_i[p] <= 1'b1;
          owed[p]--;
        end else begin
          credit_i[p] <= 1'b0;
        end
        if (pend[p].size() > 0 && up_credit[p] > 0) begin
          data_i[p]  <= pend[p][0][15:0];
          valid_i[p] <= 1'b1;
          exp_q[4 * int'(pend[p][0][17:16]) + p].push_back(pend[p][0][15:0]);
          void'(pend[p].pop_front());
          up_credit[p]--;
          injected[p]++;
        end else begin
          valid_i[p] <= 1'b0;
        end
      end
    end
  end

  initial begin
    wait (loaded);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with traffic still in flight", cycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int total;
    int npass;
    arst_n   <= 1'b0;
    valid_i  <= '0;
    credit_i <= '0;
    addr.y = 4'd0;
    addr.x = 4'd2;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      data_i[p]   <= '0;
      up_credit[p] = `BUF_DEPTH;
    end
    cur_test = 0;
    $readmemh("verification/router_input.txt", recs);
    nrec = 0;
    while (4*nrec < 256 && recs[4*nrec] != 16'h0) nrec++;
    limit  = 30 * nrec + 200;
    loaded = 1'b1;

    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    cur_test = 1;
    repeat (6) @(negedge clk);
    report(1);

    for (int t = 2; t <= 4; t++) begin
      cur_test   = t;
      e_arrivals = 0;
      prev_l     = -1;
      hold_e     = (t == 3);
      queue_records(t);
      if (t == 3) begin
        while (pend[3].size() > 0 || e_arrivals < `BUF_DEPTH) @(negedge clk);
        // Nothing more may leave east while its credits are held
        repeat (12) @(negedge clk);
        assert (e_arrivals == `BUF_DEPTH) else begin
          $display("Fail %0t: e_valid_o flit count expected %0d got %0d",
                   $time, `BUF_DEPTH, e_arrivals);
          test_err[t]++;
        end
        hold_e = 1'b0;
      end
      while (!drained()) @(negedge clk);
      report(t);
    end

    cur_test = 5;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      assert (pulses[p] == injected[p]) else begin
        $display("Fail %0t: %s_credit_o pulse count expected %0d got %0d",
                 $time, pname[p], injected[p], pulses[p]);
        test_err[5]++;
      end
    end
    report(5);

    total = 0;
    npass = 0;
    for (int t = 1; t <= NTESTS; t++) begin
      total += test_err[t];
      if (test_err[t] == 0) npass++;
    end
    $display("Tests run %0d, passed %0d, errors %0d", NTESTS, npass, total);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/router_input.txt ====
// Test, input port, expected output port and flit, all in hex
// Ports 0 south, 1 west, 2 east, 3 local, router at y 0 and x 2
02 3 0 3401
02 3 1 0102
02 0 2 0703
02 1 3 0204
02 2 1 0005
03 3 2 0a10
03 3 2 0a11
03 3 2 0a12
03 3 2 0a13
03 3 2 0a14
03 3 2 0a15
03 3 2 0a16
03 3 2 0a17
03 3 2 0a18
03 3 2 0a19
03 3 2 0a1a
03 3 2 0a1b
04 0 3 0251
04 1 3 0261
04 2 3 0271
04 0 3 0252
04 1 3 0262
04 2 3 0272
04 0 3 0253
04 1 3 0263
04 2 3 0273
00 0 0 0000
